// ==== Makefile ====
TOOL     = verilator
FLAGS    = --timing --assert
TOP      = mlpTb
FILELIST = sim.f
OBJDIR   = obj_dir
PASS_MSG = Done: no errors

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

# the run passes only if the pass line shows up in the output.
sim:
	$(TOOL) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -F "$(PASS_MSG)" > /dev/null

clean:
	rm -rf $(OBJDIR)

// ==== hdl/argMax.sv ====
`timescale 1ns/1ps
`default_nettype none

module argMax (
	input logic clk,
	input logic reset,
	input logic inValid,
	input nnPkg::outVec_t scores,
	output logic classValid,
	output logic [nnPkg::classWidth-1:0] classIndex,
	output nnPkg::act_t classScore
);

	import nnPkg::*;

	logic [classWidth-1:0] bestIndex;
	act_t bestScore;

	// unsigned compare is safe after relu. strict > keeps the lowest index on a tie.
	always_comb
	begin
		bestIndex = '0;
		bestScore = scores[0];
		for (int i = 1; i < outCount; i++)
		begin
			if ($unsigned(scores[i]) > $unsigned(bestScore))
			begin
				bestIndex = classWidth'(i);
				bestScore = scores[i];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			classValid <= 1'b0;
			classIndex <= '0;
			classScore <= '0;
		end
		else
		begin
			classValid <= inValid;
			if (inValid)
			begin
				classIndex <= bestIndex; // held until the next result.
				classScore <= bestScore;
			end
		end
	end

	for (genvar g = 0; g < outCount; g++)
	begin : gScoreCheck
		assert property (@(posedge clk) disable iff (reset)
			inValid |=> $unsigned(classScore) >= $unsigned($past(scores[g])))
			else $error("classScore %h below score %0d", classScore, g);
	end

endmodule

`default_nettype wire

// ==== hdl/denseLayer.sv ====
`timescale 1ns/1ps
`default_nettype none

module denseLayer #(
	parameter int fanIn = 15,
	parameter int width = 8,
	parameter nnPkg::act_t [width-1:0][fanIn-1:0] weights = '0,
	parameter nnPkg::act_t [width-1:0] bias = '0
) (
	input logic clk,
	input logic reset,
	input logic inValid,
	input nnPkg::act_t [fanIn-1:0] inData,
	output logic outValid,
	output nnPkg::act_t [width-1:0] outData
);

	import nnPkg::*;

	logic [neuronLatency-1:0] validPipe;

	for (genvar n = 0; n < width; n++)
	begin : gNeuron
		neuron #(
			.fanIn(fanIn),
			.weights(weights[n]),
			.bias(bias[n])
		) node (
			.clk(clk),
			.reset(reset),
			.in(inData),
			.out(outData[n])
		);
	end

	// strobe tracks the neuron pipeline.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			validPipe <= '0;
		end
		else
		begin
			validPipe <= {validPipe[neuronLatency-2:0], inValid};
		end
	end

	assign outValid = validPipe[neuronLatency-1];

	// no strobe can emerge before a fresh input has crossed the pipeline.
	assert property (@(posedge clk) reset |=> !outValid [*neuronLatency])
		else $error("layer strobe high too soon after reset");

endmodule

`default_nettype wire

// ==== hdl/mlpTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module mlpTop (
	input logic clk,
	input logic reset,
	input logic inValid,
	input nnPkg::inVec_t inData,
	output logic classValid,
	output logic [nnPkg::classWidth-1:0] classIndex,
	output nnPkg::act_t classScore
);

	import nnPkg::*;

	logic hiddenValid;
	hiddenVec_t hiddenData;
	logic scoreValid;
	outVec_t scoreData;

	denseLayer #(
		.fanIn(inCount),
		.width(hiddenCount),
		.weights(hiddenWeights),
		.bias(hiddenBias)
	) hiddenLayer (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inData(inData),
		.outValid(hiddenValid),
		.outData(hiddenData)
	);

	denseLayer #(
		.fanIn(hiddenCount),
		.width(outCount),
		.weights(outWeights),
		.bias(outBias)
	) outputLayer (
		.clk(clk),
		.reset(reset),
		.inValid(hiddenValid),
		.inData(hiddenData),
		.outValid(scoreValid),
		.outData(scoreData)
	);

	argMax classifier (
		.clk(clk),
		.reset(reset),
		.inValid(scoreValid),
		.scores(scoreData),
		.classValid(classValid),
		.classIndex(classIndex),
		.classScore(classScore)
	);

	// one result per input, exactly netLatency cycles later.
	assert property (@(posedge clk) disable iff (reset)
		inValid |-> ##netLatency classValid)
		else $error("no classValid %0d cycles after inValid", netLatency);

	assert property (@(posedge clk) disable iff (reset)
		classValid |-> $past(inValid, netLatency))
		else $error("classValid without a matching inValid");

endmodule

`default_nettype wire

// ==== hdl/neuron.sv ====
`timescale 1ns/1ps
`default_nettype none

module neuron #(
	parameter int fanIn = 15,
	parameter nnPkg::act_t [fanIn-1:0] weights = '0,
	parameter nnPkg::act_t bias = '0
) (
	input logic clk,
	input logic reset,
	input nnPkg::act_t [fanIn-1:0] in,
	output nnPkg::act_t out
);

	import nnPkg::*;

	act_t [fanIn-1:0] inReg; // edge 1.
	act_t sum; // edge 2.
	act_t acc;

	// products keep their low byte, the sum wraps at 8 bits.
	always_comb
	begin
		acc = bias;
		for (int i = 0; i < fanIn; i++)
		begin
			acc = acc + act_t'(inReg[i] * weights[i]);
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			inReg <= '0;
			sum <= '0;
			out <= '0;
		end
		else
		begin
			inReg <= in;
			sum <= acc;
			if (sum[actWidth-1])
			begin
				out <= '0; // relu clamp.
			end
			else
			begin
				out <= sum;
			end
		end
	end

	// a zero input leaves only the clamped bias, neuronLatency cycles on.
	assert property (@(posedge clk) disable iff (reset)
		(in == '0) |-> ##neuronLatency (out == (bias[actWidth-1] ? act_t'(0) : bias)))
		else $error("neuron output %h does not follow a zero input", out);

endmodule

`default_nettype wire

// ==== hdl/nnPkg.sv ====
`default_nettype none

package nnPkg;

	// word and layer sizes.
	localparam int actWidth = 8;
	localparam int inCount = 15;
	localparam int hiddenCount = 8;
	localparam int outCount = 4;
	localparam int classWidth = $clog2(outCount);

	// pipeline depths in clock cycles.
	localparam int neuronLatency = 3; // input reg, sum reg, relu reg.
	localparam int netLatency = 2 * neuronLatency + 1; // two layers plus arg-max.

	// one signed 8-bit activation, weight or bias.
	typedef logic signed [actWidth-1:0] act_t;

	// element 0 sits in the low byte.
	typedef act_t [inCount-1:0] inVec_t;
	typedef act_t [hiddenCount-1:0] hiddenVec_t;
	typedef act_t [outCount-1:0] outVec_t;

	// fixed weight and bias tables of both layers.
	`include "nnWeights.svh"

endpackage

`default_nettype wire

// ==== include/nnWeights.svh ====
`ifndef NN_WEIGHTS_SVH
`define NN_WEIGHTS_SVH

// hidden layer, one row per neuron; each row lists input 14 first, input 0 last.
localparam inVec_t [hiddenCount-1:0] hiddenWeights = {
	{8'hF1, 8'hF8, 8'h63, 8'hFA, 8'hFE, 8'hD3, 8'h0E, 8'h06,
		8'hC6, 8'hEC, 8'hE4, 8'hDE, 8'h4A, 8'hC8, 8'h12}, // neuron 7.
	{8'h0A, 8'hE7, 8'h21, 8'hF3, 8'h05, 8'h3C, 8'hD9, 8'h11,
		8'hFC, 8'h28, 8'h0B, 8'hC4, 8'h17, 8'hF6, 8'h30}, // neuron 6.
	{8'hD2, 8'h19, 8'h07, 8'hE1, 8'h44, 8'hFD, 8'h13, 8'hB8,
		8'h26, 8'h09, 8'hEE, 8'h1F, 8'h02, 8'hDB, 8'h35}, // neuron 5.
	{8'h1C, 8'h03, 8'hCA, 8'h2E, 8'hF0, 8'h0D, 8'h52, 8'hE9,
		8'h08, 8'hBD, 8'h16, 8'hFB, 8'h2A, 8'h01, 8'hE3}, // neuron 4.
	{8'h27, 8'hF4, 8'h0F, 8'h39, 8'hC1, 8'h14, 8'hFF, 8'h23,
		8'hDA, 8'h06, 8'h4C, 8'hE6, 8'h0C, 8'h31, 8'hF7}, // neuron 3.
	{8'hE8, 8'h2D, 8'h18, 8'h04, 8'hDF, 8'h29, 8'h0B, 8'hC9,
		8'h3A, 8'h12, 8'hF2, 8'h07, 8'h5D, 8'hE0, 8'h1A}, // neuron 2.
	{8'h03, 8'hD6, 8'h46, 8'h15, 8'h0E, 8'hEA, 8'h33, 8'hF9,
		8'h1B, 8'hC7, 8'h24, 8'h10, 8'hE5, 8'h38, 8'h0D}, // neuron 1.
	{8'hF5, 8'h1E, 8'hE2, 8'h4B, 8'h0A, 8'h2F, 8'hCD, 8'h16,
		8'h05, 8'hF8, 8'h3B, 8'h20, 8'hD4, 8'h09, 8'h2C}  // neuron 0.
};

// hidden biases, neuron 7 first.
localparam hiddenVec_t hiddenBias = {
	8'hF9, 8'h12, 8'hE0, 8'h05, 8'h00, 8'hF4, 8'h1A, 8'h08
};

// output layer, one row per class; each row lists hidden 7 first.
localparam hiddenVec_t [outCount-1:0] outWeights = {
	{8'h1D, 8'hE6, 8'h0C, 8'h31, 8'hF2, 8'h08, 8'h27, 8'hCA}, // class 3.
	{8'hF4, 8'h22, 8'h15, 8'hD8, 8'h3E, 8'h0B, 8'hE9, 8'h19}, // class 2.
	{8'h0E, 8'hF7, 8'h2B, 8'h13, 8'hC5, 8'h36, 8'h04, 8'hE1}, // class 1.
	{8'h26, 8'h09, 8'hDC, 8'h1F, 8'h0A, 8'hEF, 8'h34, 8'h11}  // class 0.
};

// output biases, class 3 first.
localparam outVec_t outBias = {
	8'h04, 8'hF8, 8'h10, 8'h00
};

`endif

// ==== sim.f ====
+incdir+include
hdl/nnPkg.sv
hdl/neuron.sv
hdl/denseLayer.sv
hdl/argMax.sv
hdl/mlpTop.sv
tb/mlpTb.sv

// ==== tb/mlpTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mlpTb;

	import nnPkg::*;

	`include "nnWeights.svh"

	localparam int resetCycles = 4;
	localparam int quietCycles = 10;
	localparam int directedCount = 7; // six patterns plus one tie.
	localparam int tieTries = 2000;
	localparam int b2bCount = 200;
	localparam int gapCount = 100;
	localparam int maxGap = 4;
	localparam int testCount = 6;
	localparam int drainCycles = netLatency + 2;
	localparam int cycleLimit = resetCycles + quietCycles + directedCount + 1 + b2bCount
		+ gapCount * (maxGap + 1) + testCount * (drainCycles + 1) + drainCycles + 50;

	typedef struct packed {
		int capture; // cycle in which the input was driven.
		logic [classWidth-1:0] index;
		act_t score;
	} expect_t;

	logic clk;
	logic reset;
	logic inValid;
	inVec_t inData;
	logic classValid;
	logic [classWidth-1:0] classIndex;
	act_t classScore;

	expect_t pending[$];
	int cycle = 0;
	int errorCount = 0;
	int checkCount = 0;
	int resultCount = 0;
	int vectorCount = 0;
	int errorsBefore;
	int resultsBefore;
	int vectorsBefore;

	mlpTop UUT (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inData(inData),
		.classValid(classValid),
		.classIndex(classIndex),
		.classScore(classScore)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycle <= cycle + 1;
		if (cycle >= cycleLimit)
		begin
			$display("Timeout after %0d cycles with %0d results pending", cycle, pending.size());
			$display("Done: errors found");
			$finish;
		end
	end

	// low byte of the full sum, then relu on bit 7.
	function automatic int wrapRelu(input int a);
		int w;
		w = a & 255;
		return (w >= 128) ? 0 : w;
	endfunction

	function automatic void refModel(input inVec_t x, output logic [classWidth-1:0] idx,
		output act_t score, output bit tie);
		int hidden[hiddenCount];
		int outs[outCount];
		int acc;
		int best;
		int hits;
		for (int h = 0; h < hiddenCount; h++)
		begin
			acc = int'(hiddenBias[h]);
			for (int i = 0; i < inCount; i++)
			begin
				acc = acc + int'(x[i]) * int'(hiddenWeights[h][i]);
			end
			hidden[h] = wrapRelu(acc);
		end
		for (int c = 0; c < outCount; c++)
		begin
			acc = int'(outBias[c]);
			for (int h = 0; h < hiddenCount; h++)
			begin
				acc = acc + hidden[h] * int'(outWeights[c][h]);
			end
			outs[c] = wrapRelu(acc);
		end
		idx = '0;
		best = outs[0];
		for (int c = 1; c < outCount; c++)
		begin
			if (outs[c] > best)
			begin
				best = outs[c];
				idx = classWidth'(c);
			end
		end
		hits = 0;
		for (int c = 0; c < outCount; c++)
		begin
			if (outs[c] == best)
			begin
				hits++;
			end
		end
		score = act_t'(best);
		tie = (hits > 1);
	endfunction

	function automatic inVec_t randomVector();
		inVec_t v;
		for (int i = 0; i < inCount; i++)
		begin
			v[i] = act_t'($urandom);
		end
		return v;
	endfunction

	task automatic checkIndex(input logic [classWidth-1:0] expected,
		input logic [classWidth-1:0] actual);
		checkCount++;
		if (actual !== expected)
		begin
			errorCount++;
			$display("Fail at %0t ns: classIndex expected %0d, got %0d", $time, expected, actual);
		end
	endtask

	task automatic checkScore(input act_t expected, input act_t actual);
		checkCount++;
		if (actual !== expected)
		begin
			errorCount++;
			$display("Fail at %0t ns: classScore expected %h, got %h", $time, expected, actual);
		end
	endtask

	task automatic sendVector(input inVec_t v);
		expect_t item;
		bit tie;
		@(negedge clk);
		refModel(v, item.index, item.score, tie);
		item.capture = cycle;
		inValid = 1'b1;
		inData = v;
		pending.push_back(item);
		vectorCount++;
	endtask

	task automatic idle(input int n);
		repeat (n)
		begin
			@(negedge clk);
			inValid = 1'b0;
		end
	endtask

	task automatic drain();
		idle(1);
		while (pending.size() != 0)
		begin
			@(negedge clk);
		end
	endtask

	task automatic beginTest();
		errorsBefore = errorCount;
		resultsBefore = resultCount;
		vectorsBefore = vectorCount;
	endtask

	task automatic reportTest(input string name);
		int sent;
		int got;
		sent = vectorCount - vectorsBefore;
		got = resultCount - resultsBefore;
		if (got != sent)
		begin
			errorCount++;
			$display("Result count wrong in %s: %0d sent, %0d received", name, sent, got);
		end
		$display("%s: %0d vectors, %0d errors", name, sent, errorCount - errorsBefore);
	endtask

	// outputs settle after posedge, so compare on the falling edge.
	always @(negedge clk)
	begin
		expect_t head;
		if (!reset)
		begin
			if (pending.size() != 0 && pending[0].capture + netLatency < cycle)
			begin
				head = pending.pop_front();
				errorCount++;
				$display("Missing result at %0t ns for the input driven in cycle %0d",
					$time, head.capture);
			end
			if (classValid)
			begin
				if (pending.size() == 0 || pending[0].capture >= cycle)
				begin
					errorCount++;
					$display("Spurious classValid at %0t ns with no input pending", $time);
				end
				else
				begin
					head = pending.pop_front();
					resultCount++;
					if (cycle - head.capture != netLatency)
					begin
						errorCount++;
						$display("Wrong latency at %0t ns: %0d cycles instead of %0d",
							$time, cycle - head.capture, netLatency);
					end
					checkIndex(head.index, classIndex);
					checkScore(head.score, classScore);
				end
			end
		end
	end

	initial
	begin
		inVec_t v;
		logic [classWidth-1:0] idx;
		act_t score;
		bit tie;
		bit found;
		void'($urandom(32'h5660));
		reset = 1'b1;
		inValid = 1'b0;
		inData = '0;
		repeat (resetCycles) @(negedge clk);
		reset = 1'b0;

		beginTest();
		repeat (quietCycles)
		begin
			@(negedge clk);
			checkIndex('0, classIndex);
			checkScore('0, classScore);
		end
		reportTest("after reset");

		beginTest();
		sendVector('0); // biases alone.
		drain();
		reportTest("all-zero input");

		beginTest();
		sendVector({inCount{8'h01}});
		sendVector({inCount{8'hFF}});
		sendVector({inCount{8'h7F}}); // wraps hard.
		sendVector({inCount{8'h80}});
		v = '0;
		v[0] = 8'h7F;
		sendVector(v);
		for (int i = 0; i < inCount; i++)
		begin
			v[i] = (i % 2 == 1) ? 8'h80 : 8'h7F;
		end
		sendVector(v);
		found = 1'b0;
		for (int k = 0; k < tieTries && !found; k++)
		begin
			v = randomVector();
			refModel(v, idx, score, tie);
			found = tie;
		end
		if (found)
		begin
			sendVector(v);
		end
		else
		begin
			errorCount++;
			$display("No tie vector found in %0d random candidates", tieTries);
		end
		drain();
		reportTest("directed vectors");

		beginTest();
		sendVector(randomVector());
		drain();
		idle(drainCycles); // watch for a second strobe.
		reportTest("isolated vector");

		beginTest();
		repeat (b2bCount) sendVector(randomVector());
		drain();
		reportTest("back-to-back");

		beginTest();
		repeat (gapCount)
		begin
			sendVector(randomVector());
			idle($urandom_range(maxGap, 0));
		end
		drain();
		reportTest("random gaps");

		$display("%0d vectors, %0d results, %0d checks, %0d errors",
			vectorCount, resultCount, checkCount, errorCount);
		if (errorCount == 0)
		begin
			$display("Done: no errors");
		end
		else
		begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire
